/* logic/snoop_config.svh */
// ====================
// cache geometry for the snoop slice
// line is 128 bits and leaves the CD channel as two 64-bit beats
// ways and sets must stay powers of two
// ====================

`ifndef SNOOP_CONFIG_SVH
`define SNOOP_CONFIG_SVH

// associativity
`define SNP_WAYS 4

// sets per way
`define SNP_SETS 16

// cache line in bits
`define SNP_LINE_W 128

// CD channel data width
`define SNP_BEAT_W 64

// snoop address width
`define SNP_ADDR_W 32

`endif

/* logic/snoop_pkg.sv */
// ====================
// types shared by the snoop slice
// address splits into tag, set index and line offset
// acsnoop codes follow the ACE encoding, other codes are unsupported
// ====================

package snoop_pkg;

  `include "snoop_config.svh"

  localparam int unsigned OFFSET_W  = $clog2(`SNP_LINE_W / 8);
  localparam int unsigned INDEX_W   = $clog2(`SNP_SETS);
  localparam int unsigned TAG_W     = `SNP_ADDR_W - INDEX_W - OFFSET_W;
  localparam int unsigned WAY_IDX_W = $clog2(`SNP_WAYS);

  typedef logic [`SNP_ADDR_W-1:0] addr_t;
  typedef logic [INDEX_W-1:0]     index_t;
  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [`SNP_WAYS-1:0]   way_vec_t;
  typedef logic [WAY_IDX_W-1:0]   way_idx_t;
  typedef logic [`SNP_LINE_W-1:0] line_t;
  typedef logic [`SNP_BEAT_W-1:0] beat_t;

  typedef enum logic [3:0] {
    READ_ONCE     = 4'b0000,
    READ_SHARED   = 4'b0001,
    READ_UNIQUE   = 4'b0111,
    CLEAN_INVALID = 4'b1001
  } acsnoop_e;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    EVAL_FLAGS,
    UPDATE_SHARED,
    INVALIDATE,
    SEND_CR,
    SEND_CD
  } ctrl_state_e;

  typedef struct packed {
    addr_t    addr;
    acsnoop_e snoop;
  } ac_req_t;

  typedef struct packed {
    logic data_transfer;
    logic pass_dirty;
    logic is_shared;
    logic error;
  } cr_resp_t;

  typedef struct packed {
    beat_t data;
    logic  last;
  } cd_beat_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    logic shared;
  } line_flags_t;

  // flags_we writes the flags, data_we writes tag and data together
  typedef struct packed {
    index_t      index;
    logic        we;
    logic        flags_we;
    logic        data_we;
    line_flags_t flags;
    tag_t        tag;
    line_t       data;
  } way_access_t;

  typedef struct packed {
    tag_t        tag;
    line_flags_t flags;
    line_t       data;
  } way_rd_t;

  typedef struct packed {
    logic        valid;
    way_idx_t    way;
    addr_t       addr;
    line_flags_t flags;
    line_t       data;
  } fill_req_t;

  function automatic index_t addr_index(addr_t addr);
    return addr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic tag_t addr_tag(addr_t addr);
    return addr[OFFSET_W + INDEX_W +: TAG_W];
  endfunction

endpackage

/* logic/way_arbiter.sv */
// ====================
// fill writes win over snoop accesses
// fill is never stalled, the snoop side just waits
// ====================

`timescale 1ns/1ps

module way_arbiter import snoop_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fill_req_t   fill_i,
  input  way_vec_t    req_i,
  input  way_access_t acc_i,
  output logic        gnt_o,
  output way_vec_t    en_o,
  output way_access_t acc_o
);

  way_vec_t fill_sel;

  // decoded way of the fill
  assign fill_sel = way_vec_t'(1) << fill_i.way;

  assign gnt_o = !fill_i.valid && (|req_i);

  always_comb begin
    if (fill_i.valid) begin
      en_o           = fill_sel;
      acc_o.index    = addr_index(fill_i.addr);
      acc_o.we       = 1'b1;
      acc_o.flags_we = 1'b1;
      acc_o.data_we  = 1'b1;
      acc_o.flags    = fill_i.flags;
      acc_o.tag      = addr_tag(fill_i.addr);
      acc_o.data     = fill_i.data;
    end else begin
      en_o  = req_i;
      acc_o = acc_i;
    end
  end

  // snoop writes only ever target the single hit way
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o && acc_i.we |-> $onehot(req_i));

endmodule

/* logic/cache_way.sv */
// ====================
// one way of the cache
// read data shows up one cycle after an enabled read
// only the flags come out of reset
// ====================

`timescale 1ns/1ps

`include "snoop_config.svh"

module cache_way import snoop_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        en_i,
  input  way_access_t acc_i,
  output way_rd_t     rd_o
);

  line_flags_t flags_q [`SNP_SETS];
  tag_t        tag_q   [`SNP_SETS];
  line_t       data_q  [`SNP_SETS];
  way_rd_t     rd_q;

  logic wr_en;
  logic rd_en;

  assign wr_en = en_i && acc_i.we;
  assign rd_en = en_i && !acc_i.we;

  // flag array
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `SNP_SETS; i++) begin
        flags_q[i] <= '0;
      end
    end else if (wr_en && acc_i.flags_we) begin
      flags_q[acc_i.index] <= acc_i.flags;
    end
  end

  // tag and data arrays, written as one class
  always_ff @(posedge clk_i) begin
    if (wr_en && acc_i.data_we) begin
      tag_q[acc_i.index]  <= acc_i.tag;
      data_q[acc_i.index] <= acc_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_q.tag   <= tag_q[acc_i.index];
      rd_q.flags <= flags_q[acc_i.index];
      rd_q.data  <= data_q[acc_i.index];
    end
  end

  assign rd_o = rd_q;

endmodule

/* logic/way_merge.sv */
// ====================
// combines the way read results
// expects at most one hit way
// ====================

`timescale 1ns/1ps

`include "snoop_config.svh"

module way_merge import snoop_pkg::*; (
  input  tag_t     tag_i,
  input  way_rd_t  rd_i [`SNP_WAYS],
  output way_vec_t hit_way_o,
  output logic     dirty_o,
  output logic     shared_o,
  output line_t    line_o
);

  always_comb begin
    hit_way_o = '0;
    dirty_o   = 1'b0;
    shared_o  = 1'b0;
    line_o    = '0;
    for (int w = 0; w < `SNP_WAYS; w++) begin
      hit_way_o[w] = rd_i[w].flags.valid && (rd_i[w].tag == tag_i);
      if (hit_way_o[w]) begin
        dirty_o  = dirty_o | rd_i[w].flags.dirty;
        shared_o = shared_o | rd_i[w].flags.shared;
        line_o   = rd_i[w].data;
      end
    end
  end

endmodule

/* logic/snoop_ctrl.sv */
// ====================
// snoop FSM, one snoop in flight at a time
// ac_ready_o drops until CR (or the last CD beat) is taken
// line leaves low half first on CD
// ====================

`timescale 1ns/1ps

`include "snoop_config.svh"

module snoop_ctrl import snoop_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        bypass_i,
  // AC channel
  input  logic        ac_valid_i,
  input  ac_req_t     ac_i,
  output logic        ac_ready_o,
  // CR channel
  output logic        cr_valid_o,
  output cr_resp_t    cr_o,
  input  logic        cr_ready_i,
  // CD channel
  output logic        cd_valid_o,
  output cd_beat_t    cd_o,
  input  logic        cd_ready_i,
  // way array side
  output way_vec_t    req_o,
  input  logic        gnt_i,
  output way_access_t acc_o,
  input  way_vec_t    hit_way_i,
  input  logic        dirty_i,
  input  logic        shared_i,
  input  line_t       line_i,
  // to the miss handler
  output logic        invalidate_o,
  output addr_t       invalidate_addr_o
);

  ctrl_state_e state_q, state_d;
  ac_req_t     ac_q, ac_d;
  cr_resp_t    cr_q, cr_d;
  way_vec_t    hit_way_q, hit_way_d;
  logic        dirty_q, dirty_d;
  logic        beat_q, beat_d;
  line_t       line_q, line_d;

  assign ac_ready_o = (state_q == IDLE);
  assign cr_valid_o = (state_q == SEND_CR);
  assign cd_valid_o = (state_q == SEND_CD);
  assign cr_o       = cr_q;

  assign cd_o.data = beat_q ? line_q[2*`SNP_BEAT_W-1:`SNP_BEAT_W] : line_q[`SNP_BEAT_W-1:0];
  assign cd_o.last = beat_q;

  assign invalidate_addr_o = ac_q.addr;

  always_comb begin
    state_d   = state_q;
    ac_d      = ac_q;
    cr_d      = cr_q;
    hit_way_d = hit_way_q;
    dirty_d   = dirty_q;
    beat_d    = beat_q;
    line_d    = line_q;

    req_o        = '0;
    invalidate_o = 1'b0;

    // access always points at the latched set, tag also feeds the merge
    acc_o       = '0;
    acc_o.index = addr_index(ac_q.addr);
    acc_o.tag   = addr_tag(ac_q.addr);

    case (state_q)
      IDLE: begin
        beat_d = 1'b0;
        if (ac_valid_i) begin
          ac_d = ac_i;
          cr_d = '0;
          if (bypass_i) begin
            state_d = SEND_CR;
          end else if (ac_i.snoop inside {READ_ONCE, READ_SHARED, READ_UNIQUE,
                                          CLEAN_INVALID}) begin
            state_d = WAIT_GNT;
          end else begin
            // unsupported snoop type
            cr_d.error = 1'b1;
            state_d    = SEND_CR;
          end
        end
      end

      WAIT_GNT: begin
        req_o = '1;
        if (gnt_i) begin
          state_d = EVAL_FLAGS;
        end
      end

      EVAL_FLAGS: begin
        hit_way_d = hit_way_i;
        dirty_d   = dirty_i;
        line_d    = line_i;
        if (|hit_way_i) begin
          cr_d.data_transfer = 1'b1;
          cr_d.pass_dirty    = 1'b0;
          cr_d.is_shared     = 1'b0;
          case (ac_q.snoop)
            READ_ONCE: begin
              cr_d.is_shared = shared_i;
              state_d        = SEND_CR;
            end
            READ_SHARED: begin
              cr_d.is_shared = 1'b1;
              state_d        = UPDATE_SHARED;
            end
            READ_UNIQUE: begin
              cr_d.pass_dirty = dirty_i;
              state_d         = INVALIDATE;
            end
            default: begin
              // clean-invalid only moves data when it is dirty
              cr_d.data_transfer = dirty_i;
              cr_d.pass_dirty    = dirty_i;
              state_d            = INVALIDATE;
            end
          endcase
        end else begin
          cr_d    = '0;
          state_d = SEND_CR;
        end
      end

      UPDATE_SHARED: begin
        req_o              = hit_way_q;
        acc_o.we           = 1'b1;
        acc_o.flags_we     = 1'b1;
        acc_o.flags.valid  = 1'b1;
        acc_o.flags.dirty  = dirty_q;
        acc_o.flags.shared = 1'b1;
        if (gnt_i) begin
          state_d = SEND_CR;
        end
      end

      INVALIDATE: begin
        req_o          = hit_way_q;
        acc_o.we       = 1'b1;
        acc_o.flags_we = 1'b1;
        // flags stay zero, line goes invalid
        invalidate_o   = gnt_i;
        if (gnt_i) begin
          state_d = SEND_CR;
        end
      end

      SEND_CR: begin
        if (cr_ready_i) begin
          state_d = cr_q.data_transfer ? SEND_CD : IDLE;
        end
      end

      SEND_CD: begin
        if (cd_ready_i) begin
          beat_d = ~beat_q;
          if (beat_q) begin
            state_d = IDLE;
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      ac_q      <= '0;
      cr_q      <= '0;
      hit_way_q <= '0;
      dirty_q   <= 1'b0;
      beat_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      ac_q      <= ac_d;
      cr_q      <= cr_d;
      hit_way_q <= hit_way_d;
      dirty_q   <= dirty_d;
      beat_q    <= beat_d;
    end
  end

  always_ff @(posedge clk_i) begin
    line_q <= line_d;
  end

  // a set never holds the same tag twice
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == EVAL_FLAGS |-> $onehot0(hit_way_i));

  // CR held until the interconnect takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cr_valid_o && !cr_ready_i |=> cr_valid_o && $stable(cr_o));

endmodule

/* logic/snoop_cache.sv */
// ====================
// snoop-side cache slice top
// fill_i is a one-cycle write that is always taken
// ====================

`timescale 1ns/1ps

`include "snoop_config.svh"

module snoop_cache import snoop_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      bypass_i,
  input  logic      ac_valid_i,
  input  ac_req_t   ac_i,
  output logic      ac_ready_o,
  output logic      cr_valid_o,
  output cr_resp_t  cr_o,
  input  logic      cr_ready_i,
  output logic      cd_valid_o,
  output cd_beat_t  cd_o,
  input  logic      cd_ready_i,
  output logic      invalidate_o,
  output addr_t     invalidate_addr_o,
  input  fill_req_t fill_i
);

  way_vec_t    ctrl_req;
  way_access_t ctrl_acc;
  logic        gnt;
  way_vec_t    way_en;
  way_access_t way_acc;
  way_rd_t     way_rd [`SNP_WAYS];
  way_vec_t    hit_way;
  logic        dirty;
  logic        shared;
  line_t       hit_line;

  snoop_ctrl i_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bypass_i          (bypass_i),
    .ac_valid_i        (ac_valid_i),
    .ac_i              (ac_i),
    .ac_ready_o        (ac_ready_o),
    .cr_valid_o        (cr_valid_o),
    .cr_o              (cr_o),
    .cr_ready_i        (cr_ready_i),
    .cd_valid_o        (cd_valid_o),
    .cd_o              (cd_o),
    .cd_ready_i        (cd_ready_i),
    .req_o             (ctrl_req),
    .gnt_i             (gnt),
    .acc_o             (ctrl_acc),
    .hit_way_i         (hit_way),
    .dirty_i           (dirty),
    .shared_i          (shared),
    .line_i            (hit_line),
    .invalidate_o      (invalidate_o),
    .invalidate_addr_o (invalidate_addr_o)
  );

  way_arbiter i_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .fill_i (fill_i),
    .req_i  (ctrl_req),
    .acc_i  (ctrl_acc),
    .gnt_o  (gnt),
    .en_o   (way_en),
    .acc_o  (way_acc)
  );

  for (genvar w = 0; w < `SNP_WAYS; w++) begin : g_way
    cache_way i_way (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .en_i   (way_en[w]),
      .acc_i  (way_acc),
      .rd_o   (way_rd[w])
    );
  end

  // compare against the tag the controller latched
  way_merge i_merge (
    .tag_i     (ctrl_acc.tag),
    .rd_i      (way_rd),
    .hit_way_o (hit_way),
    .dirty_o   (dirty),
    .shared_o  (shared),
    .line_o    (hit_line)
  );

endmodule

/* bench/snoop_checker.sv */
// ====================
// response checker for the snoop slice
// samples on the falling edge, where DUT outputs and bench drives are settled
// a test closes on a CR without data or on the last CD beat
// ====================

`timescale 1ns/1ps

module snoop_checker import snoop_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // expected values of the running test
  input  int       case_idx_i,
  input  cr_resp_t exp_cr_i,
  input  line_t    exp_line_i,
  input  logic     exp_inv_i,
  input  addr_t    exp_addr_i,
  // observed DUT outputs
  input  logic     ac_ready_i,
  input  logic     cr_valid_i,
  input  cr_resp_t cr_i,
  input  logic     cr_ready_i,
  input  logic     cd_valid_i,
  input  cd_beat_t cd_i,
  input  logic     cd_ready_i,
  input  logic     inv_i,
  input  addr_t    inv_addr_i,
  output int       done_cnt_o,
  output int       err_cnt_o
);

  logic  in_cd;
  logic  beat;
  logic  inv_seen;
  int    case_errs;
  beat_t exp_beat;

  task automatic flag_mismatch(string msg);
    $display("ERR %0t: test %0d %s", $time, case_idx_i, msg);
    case_errs++;
    err_cnt_o++;
  endtask

  task automatic flag_protocol(string msg);
    $display("test %0d: %s", case_idx_i, msg);
    case_errs++;
    err_cnt_o++;
  endtask

  task automatic close_case();
    if (inv_seen != exp_inv_i) begin
      flag_mismatch($sformatf("invalidate seen %0b, expected %0b", inv_seen, exp_inv_i));
    end
    if (case_errs == 0) begin
      $display("test %0d passed", case_idx_i);
    end else begin
      $display("test %0d failed with %0d errors", case_idx_i, case_errs);
    end
    case_errs = 0;
    inv_seen  = 1'b0;
    in_cd     = 1'b0;
    beat      = 1'b0;
    done_cnt_o++;
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      in_cd      = 1'b0;
      beat       = 1'b0;
      inv_seen   = 1'b0;
      case_errs  = 0;
      done_cnt_o = 0;
      err_cnt_o  = 0;
    end else begin
      // no new snoop may be taken while a response is still owed
      if (ac_ready_i && (cr_valid_i || cd_valid_i)) begin
        flag_protocol("AC ready was high while a response was still pending");
      end

      if (inv_i) begin
        if (inv_seen) begin
          flag_protocol("invalidate pulsed more than once");
        end
        inv_seen = 1'b1;
        if (inv_addr_i !== exp_addr_i) begin
          flag_mismatch($sformatf("invalidate address %h, expected %h", inv_addr_i, exp_addr_i));
        end
      end

      if (cr_valid_i && cr_ready_i) begin
        if (in_cd) begin
          flag_protocol("CR arrived while CD beats were still owed");
        end
        if (cr_i !== exp_cr_i) begin
          flag_mismatch($sformatf("CR is %b, expected %b", cr_i, exp_cr_i));
        end
        // follow what the DUT announced so the beats stay in step
        if (cr_i.data_transfer) begin
          in_cd = 1'b1;
          beat  = 1'b0;
        end else begin
          close_case();
        end
      end

      if (cd_valid_i && cd_ready_i) begin
        if (!in_cd) begin
          flag_protocol("CD beat arrived without a data transfer response");
        end else begin
          exp_beat = beat ? exp_line_i[127:64] : exp_line_i[63:0];
          if (cd_i.data !== exp_beat) begin
            flag_mismatch($sformatf("CD beat %0d is %h, expected %h", beat, cd_i.data, exp_beat));
          end
          if (cd_i.last !== beat) begin
            flag_mismatch($sformatf("CD beat %0d has last %b", beat, cd_i.last));
          end
          if (beat) begin
            close_case();
          end else begin
            beat = 1'b1;
          end
        end
      end
    end
  end

endmodule

/* bench/tb_snoop_cache.sv */
// ====================
// testbench for the snoop slice
// lines are preloaded through the fill port before any snoop
// CR/CD ready and extra fills to set 15 are random from a fixed seed
// ====================

`timescale 1ns/1ps

module tb_snoop_cache import snoop_pkg::*; ();

  typedef struct packed {
    logic       bypass;
    logic [3:0] snoop;
    addr_t      addr;
    cr_resp_t   exp_cr;
    logic       exp_inv;
  } case_t;

  localparam int CYCLE_LIMIT = 200;

  localparam addr_t ADDR_A = 32'h1234_5010;
  localparam addr_t ADDR_S = 32'h5555_5010;
  localparam addr_t ADDR_B = 32'h0000_A020;
  localparam addr_t ADDR_C = 32'h00BE_EF30;
  localparam addr_t ADDR_D = 32'h0CAF_E040;
  localparam addr_t ADDR_E = 32'h0777_7050;
  localparam addr_t ADDR_G = 32'h0ABC_D060;
  localparam addr_t ADDR_M = 32'h0F00_0070;
  localparam addr_t ADDR_H = 32'h0D0D_D0F0;

  logic      clk;
  logic      rst_n;
  logic      bypass;
  logic      ac_valid;
  ac_req_t   ac;
  logic      ac_ready;
  logic      cr_valid;
  cr_resp_t  cr;
  logic      cr_ready;
  logic      cd_valid;
  cd_beat_t  cd;
  logic      cd_ready;
  logic      inv;
  addr_t     inv_addr;
  fill_req_t fill;

  integer    seed = 4792;
  logic      preload_done;
  logic      timed_out;
  case_t     cases[$];
  int        case_idx;
  cr_resp_t  exp_cr;
  line_t     exp_line;
  logic      exp_inv;
  addr_t     exp_addr;
  int        done_cnt;
  int        err_cnt;

  // line contents are a function of the full line address
  function automatic line_t line_of(addr_t addr);
    return {addr ^ 32'hC3C3_5A5A, ~addr, addr + 32'h1111_1111, {addr[15:0], addr[31:16]}};
  endfunction

  function automatic fill_req_t make_fill(way_idx_t way, addr_t addr, line_flags_t flags);
    fill_req_t f;
    f.valid = 1'b1;
    f.way   = way;
    f.addr  = addr;
    f.flags = flags;
    f.data  = line_of(addr);
    return f;
  endfunction

  function automatic void add_case(logic byp, logic [3:0] snp, addr_t addr,
                                   logic [3:0] cr_bits, logic inv_exp);
    case_t c;
    c.bypass  = byp;
    c.snoop   = snp;
    c.addr    = addr;
    c.exp_cr  = cr_bits;
    c.exp_inv = inv_exp;
    cases.push_back(c);
  endfunction

  // CR bits are data_transfer, pass_dirty, is_shared, error
  function automatic void build_table();
    add_case(1'b0, READ_ONCE,     ADDR_A, 4'b1000, 1'b0);
    add_case(1'b0, READ_ONCE,     ADDR_B, 4'b1010, 1'b0);
    add_case(1'b0, READ_ONCE,     ADDR_S, 4'b1010, 1'b0);
    add_case(1'b0, READ_SHARED,   ADDR_G, 4'b1010, 1'b0);
    add_case(1'b0, READ_ONCE,     ADDR_G, 4'b1010, 1'b0);
    add_case(1'b0, READ_UNIQUE,   ADDR_C, 4'b1100, 1'b1);
    add_case(1'b0, READ_ONCE,     ADDR_C, 4'b0000, 1'b0);
    add_case(1'b0, CLEAN_INVALID, ADDR_D, 4'b1100, 1'b1);
    add_case(1'b0, READ_ONCE,     ADDR_D, 4'b0000, 1'b0);
    // clean line, invalidated but no data moves
    add_case(1'b0, CLEAN_INVALID, ADDR_E, 4'b0000, 1'b1);
    add_case(1'b0, READ_ONCE,     ADDR_E, 4'b0000, 1'b0);
    add_case(1'b0, READ_ONCE,     ADDR_M, 4'b0000, 1'b0);
    add_case(1'b0, 4'b0010,       ADDR_A, 4'b0001, 1'b0);
    add_case(1'b1, READ_UNIQUE,   ADDR_A, 4'b0000, 1'b0);
    add_case(1'b1, CLEAN_INVALID, ADDR_B, 4'b0000, 1'b0);
    // bypass left A and B untouched
    add_case(1'b0, READ_ONCE,     ADDR_A, 4'b1000, 1'b0);
    add_case(1'b0, READ_ONCE,     ADDR_B, 4'b1010, 1'b0);
    add_case(1'b0, READ_ONCE,     ADDR_H, 4'b1000, 1'b0);
  endfunction

  snoop_cache uut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .bypass_i          (bypass),
    .ac_valid_i        (ac_valid),
    .ac_i              (ac),
    .ac_ready_o        (ac_ready),
    .cr_valid_o        (cr_valid),
    .cr_o              (cr),
    .cr_ready_i        (cr_ready),
    .cd_valid_o        (cd_valid),
    .cd_o              (cd),
    .cd_ready_i        (cd_ready),
    .invalidate_o      (inv),
    .invalidate_addr_o (inv_addr),
    .fill_i            (fill)
  );

  snoop_checker i_chk (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .case_idx_i (case_idx),
    .exp_cr_i   (exp_cr),
    .exp_line_i (exp_line),
    .exp_inv_i  (exp_inv),
    .exp_addr_i (exp_addr),
    .ac_ready_i (ac_ready),
    .cr_valid_i (cr_valid),
    .cr_i       (cr),
    .cr_ready_i (cr_ready),
    .cd_valid_i (cd_valid),
    .cd_i       (cd),
    .cd_ready_i (cd_ready),
    .inv_i      (inv),
    .inv_addr_i (inv_addr),
    .done_cnt_o (done_cnt),
    .err_cnt_o  (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // preload, then random back-pressure and background fills of H
  initial begin
    fill         = '0;
    cr_ready     = 1'b0;
    cd_ready     = 1'b0;
    preload_done = 1'b0;
    repeat (18) @(posedge clk);
    @(posedge clk) fill <= make_fill(2'd0, ADDR_A, 3'b100);
    @(posedge clk) fill <= make_fill(2'd3, ADDR_S, 3'b101);
    @(posedge clk) fill <= make_fill(2'd1, ADDR_B, 3'b101);
    @(posedge clk) fill <= make_fill(2'd2, ADDR_C, 3'b110);
    @(posedge clk) fill <= make_fill(2'd3, ADDR_D, 3'b110);
    @(posedge clk) fill <= make_fill(2'd0, ADDR_E, 3'b100);
    @(posedge clk) fill <= make_fill(2'd1, ADDR_G, 3'b100);
    @(posedge clk) fill <= make_fill(2'd2, ADDR_H, 3'b100);
    @(posedge clk) fill <= '0;
    preload_done <= 1'b1;
    forever begin
      @(posedge clk);
      cr_ready <= ($random(seed) & 3) != 0;
      cd_ready <= ($random(seed) & 3) != 0;
      if (($random(seed) & 7) == 0) begin
        fill <= make_fill(2'd2, ADDR_H, 3'b100);
      end else begin
        fill <= '0;
      end
    end
  end

  task automatic wait_preload();
    int n;
    n = 0;
    while (!preload_done && n < CYCLE_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!preload_done) begin
      $display("timeout waiting for the fill preload to finish");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(posedge clk);
    while (!ac_ready && n < CYCLE_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!ac_ready) begin
      $display("timeout waiting for the AC channel to become ready");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_done(int target);
    int n;
    n = 0;
    while (done_cnt < target && n < CYCLE_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) begin
      $display("timeout waiting for the response of test %0d", case_idx);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_case(int i);
    int      target;
    ac_req_t req;
    target = done_cnt + 1;
    wait_ready();
    if (!timed_out) begin
      case_idx  = i;
      exp_cr    = cases[i].exp_cr;
      exp_line  = line_of(cases[i].addr);
      exp_inv   = cases[i].exp_inv;
      exp_addr  = cases[i].addr;
      req.addr  = cases[i].addr;
      req.snoop = acsnoop_e'(cases[i].snoop);
      bypass   <= cases[i].bypass;
      ac       <= req;
      ac_valid <= 1'b1;
      @(posedge clk);
      ac_valid <= 1'b0;
      wait_done(target);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    bypass    = 1'b0;
    ac_valid  = 1'b0;
    ac        = '0;
    timed_out = 1'b0;
    case_idx  = 0;
    exp_cr    = '0;
    exp_line  = '0;
    exp_inv   = 1'b0;
    exp_addr  = '0;
    build_table();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    wait_preload();
    foreach (cases[i]) begin
      if (!timed_out) begin
        run_case(i);
      end
    end
    @(posedge clk);
    $display("tests done %0d of %0d, errors %0d", done_cnt, cases.size(), err_cnt);
    if (timed_out || err_cnt != 0 || done_cnt != cases.size()) begin
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/snoop_pkg.sv
logic/way_arbiter.sv
logic/cache_way.sv
logic/way_merge.sv
logic/snoop_ctrl.sv
logic/snoop_cache.sv
bench/snoop_checker.sv
bench/tb_snoop_cache.sv

/* Bender.yml */
package:
  name: snoop_cache

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/snoop_pkg.sv
      - logic/way_arbiter.sv
      - logic/cache_way.sv
      - logic/way_merge.sv
      - logic/snoop_ctrl.sv
      - logic/snoop_cache.sv
  - target: test
    files:
      - bench/snoop_checker.sv
      - bench/tb_snoop_cache.sv
